//--- common/fetch_pkg.sv
/*
  fetch subsystem package
  word sizes, memory geometry, boot vector, compressed-instruction rule
  and the state and owner encodings shared by fetch, port and arbiter
*/
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////
  // widths and memory geometry
  //////////////////////////////////////////////////

  // address, data word and instruction width
  localparam int XLEN = 32;

  // word address width of the instruction memory, 256 words
  localparam int MEM_AW = 8;

  // number of words in the memory array
  localparam int MEM_WORDS = 1 << MEM_AW;

  // pc loaded by reset
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

  // low two bits of a halfword, all ones marks a 32-bit instruction
  // anything else is a compressed 16-bit instruction
  localparam logic [1:0] INSTR_C_MASK = 2'b11;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // fetch sequencing
  typedef enum logic [1:0] {
    // reset, nothing requested yet
    IDLE       = 2'b00,
    // one word request outstanding
    WAIT_RESP  = 2'b01,
    // serving halfwords out of the buffered word
    HAVE_WORD  = 2'b10,
    // upper half of a straddling instruction is on its way
    FETCH_NEXT = 2'b11
  } fetch_state_e;

  // memory owner as seen by the arbiter
  typedef enum logic {
    OWN_FETCH = 1'b0,
    OWN_DATA  = 1'b1
  } arb_owner_e;

endpackage

`default_nettype wire

//--- source/instr_mem.sv
/*
  instruction memory
  single-port word array, synchronous write and registered read,
  rvalid one cycle after every accepted request
*/
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         req_i,
  input  wire                         we_i,
  input  wire [fetch_pkg::MEM_AW-1:0] addr_i,
  input  wire [fetch_pkg::XLEN-1:0]   wdata_i,
  output logic [fetch_pkg::XLEN-1:0]  rdata_o,
  output logic                        rvalid_o
);

  logic [fetch_pkg::XLEN-1:0] mem_array [fetch_pkg::MEM_WORDS];

  // array access, read data holds over writes
  always_ff @(posedge clk) begin
    if (req_i) begin
      if (we_i) begin
        mem_array[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_array[addr_i];
      end
    end
  end

  // response strobe, also the write acknowledge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
/*
  memory arbiter
  round-robin between the fetch port and the data port on one memory
  and routing of the one-cycle response back to the granted master
*/
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                          clk,
  input  wire                          rst_n,
  // fetch master
  input  wire                          fetch_req_i,
  input  wire [fetch_pkg::MEM_AW-1:0]  fetch_addr_i,
  output logic                         fetch_gnt_o,
  output logic                         fetch_rvalid_o,
  output logic [fetch_pkg::XLEN-1:0]   fetch_rdata_o,
  // data master
  input  wire                          data_req_i,
  input  wire                          data_we_i,
  input  wire [fetch_pkg::MEM_AW-1:0]  data_addr_i,
  input  wire [fetch_pkg::XLEN-1:0]    data_wdata_i,
  output logic                         data_gnt_o,
  output logic                         data_rvalid_o,
  output logic [fetch_pkg::XLEN-1:0]   data_rdata_o,
  // memory
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [fetch_pkg::MEM_AW-1:0] mem_addr_o,
  output logic [fetch_pkg::XLEN-1:0]   mem_wdata_o,
  input  wire [fetch_pkg::XLEN-1:0]    mem_rdata_i
);

  // winner of the last contested cycle and owner of the last grant
  fetch_pkg::arb_owner_e last_win_q, owner_q;
  logic rsp_q;
  logic contest;

  assign contest = fetch_req_i && data_req_i;

  // on conflict the loser of the previous conflict goes first
  assign fetch_gnt_o = fetch_req_i && (!data_req_i || (last_win_q == fetch_pkg::OWN_DATA));
  assign data_gnt_o  = data_req_i && (!fetch_req_i || (last_win_q == fetch_pkg::OWN_FETCH));

  assign mem_req_o   = fetch_gnt_o || data_gnt_o;
  assign mem_we_o    = data_gnt_o && data_we_i;
  assign mem_addr_o  = data_gnt_o ? data_addr_i : fetch_addr_i;
  assign mem_wdata_o = data_wdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_win_q <= fetch_pkg::OWN_DATA;
      owner_q    <= fetch_pkg::OWN_FETCH;
      rsp_q      <= 1'b0;
    end else begin
      rsp_q <= mem_req_o;
      if (mem_req_o) begin
        owner_q <= data_gnt_o ? fetch_pkg::OWN_DATA : fetch_pkg::OWN_FETCH;
      end
      if (contest) begin
        last_win_q <= data_gnt_o ? fetch_pkg::OWN_DATA : fetch_pkg::OWN_FETCH;
      end
    end
  end

  // response steering to the granted master with shared read data
  assign fetch_rvalid_o = rsp_q && (owner_q == fetch_pkg::OWN_FETCH);
  assign data_rvalid_o  = rsp_q && (owner_q == fetch_pkg::OWN_DATA);
  assign fetch_rdata_o  = mem_rdata_i;
  assign data_rdata_o   = mem_rdata_i;

  a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(fetch_gnt_o && data_gnt_o));

endmodule

`default_nettype wire

//--- fetch/fetch_mem_port.sv
/*
  fetch memory port
  turns fetch word requests into request/grant/response-valid cycles,
  keeps at most one response outstanding and swallows responses that
  were in flight when a redirect dropped them
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_port (
  input  wire                          clk,
  input  wire                          rst_n,
  // fetch unit side
  input  wire                          port_req_i,
  input  wire [fetch_pkg::XLEN-1:0]    port_addr_i,
  output logic                         port_ack_o,
  output logic [fetch_pkg::XLEN-1:0]   port_rdata_o,
  input  wire                          port_drop_i,
  // arbiter side
  output logic                         fetch_req_o,
  output logic [fetch_pkg::MEM_AW-1:0] fetch_addr_o,
  input  wire                          fetch_gnt_i,
  input  wire                          fetch_rvalid_i,
  input  wire [fetch_pkg::XLEN-1:0]    fetch_rdata_i
);

  // IDLE free, FETCH_NEXT request on the arbiter, WAIT_RESP granted
  fetch_pkg::fetch_state_e state_q;
  logic stale_q;
  logic [fetch_pkg::MEM_AW-1:0] addr_q;
  logic take;

  // latch a new request only when free, never in a drop cycle
  assign take = (state_q == fetch_pkg::IDLE) && port_req_i && !port_drop_i;

  assign fetch_req_o  = (state_q == fetch_pkg::FETCH_NEXT);
  assign fetch_addr_o = addr_q;

  // stale or just-dropped responses never reach the fetch unit
  assign port_ack_o   = fetch_rvalid_i && !stale_q && !port_drop_i;
  assign port_rdata_o = fetch_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
      stale_q <= 1'b0;
    end else begin
      unique case (state_q)
        fetch_pkg::IDLE:       if (take) state_q <= fetch_pkg::FETCH_NEXT;
        fetch_pkg::FETCH_NEXT: if (fetch_gnt_i) state_q <= fetch_pkg::WAIT_RESP;
        fetch_pkg::WAIT_RESP:  if (fetch_rvalid_i) state_q <= fetch_pkg::IDLE;
        default:               state_q <= fetch_pkg::IDLE;
      endcase
      // request still in flight when drop hits becomes stale
      if (port_drop_i && ((state_q == fetch_pkg::FETCH_NEXT) ||
                          ((state_q == fetch_pkg::WAIT_RESP) && !fetch_rvalid_i))) begin
        stale_q <= 1'b1;
      end else if (fetch_rvalid_i) begin
        stale_q <= 1'b0;
      end
    end
  end

  // byte address to word address
  always_ff @(posedge clk) begin
    if (take) begin
      addr_q <= port_addr_i[fetch_pkg::MEM_AW+1:2];
    end
  end

  // every response belongs to the single granted request
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_rvalid_i |-> (state_q == fetch_pkg::WAIT_RESP));

  // arbiter answers exactly one cycle after the grant
  a_resp_next_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_req_o && fetch_gnt_i) |=> fetch_rvalid_i);

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
/*
  instruction fetch unit
  keeps the fetch pc and a two-word realignment buffer, splits words into
  16-bit and 32-bit instructions and hands them out through an output
  register with a valid/ready handshake, redirect restarts the stream
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                        clk,
  input  wire                        rst_n,
  // redirect from the consumer
  input  wire                        redirect_i,
  input  wire [fetch_pkg::XLEN-1:0]  redirect_pc_i,
  // instruction stream to the consumer
  output logic                       instr_valid_o,
  input  wire                        instr_ready_i,
  output logic [fetch_pkg::XLEN-1:0] instr_o,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  // word requests to the memory port
  output logic                       port_req_o,
  output logic [fetch_pkg::XLEN-1:0] port_addr_o,
  input  wire                        port_ack_i,
  input  wire [fetch_pkg::XLEN-1:0]  port_rdata_i,
  output logic                       port_drop_o
);

  fetch_pkg::fetch_state_e state_q, state_d;

  // word address of rbuf_q[0] and halfword offset inside it
  logic [fetch_pkg::XLEN-1:0] fetch_addr_q, fetch_addr_d;
  logic off_q, off_d;
  // set while rbuf_q holds both halves of a straddling instruction
  logic strad_q, strad_d;
  // [0] newest word, [1] the word before it
  logic [1:0][fetch_pkg::XLEN-1:0] rbuf_q;

  logic out_valid_q;
  logic [fetch_pkg::XLEN-1:0] out_instr_q, out_pc_q;

  logic out_free, deliver, cur_is_c;
  logic [15:0] cur_half;
  logic [fetch_pkg::XLEN-1:0] dlv_instr, dlv_pc;

  // output register can take a new entry this cycle
  assign out_free = !out_valid_q || instr_ready_i;

  // halfword the pc points at and its length
  assign cur_half = off_q ? rbuf_q[0][31:16] : rbuf_q[0][15:0];
  assign cur_is_c = (cur_half[1:0] & fetch_pkg::INSTR_C_MASK) != fetch_pkg::INSTR_C_MASK;

  //////////////////////////////////////////////////
  // fetch fsm
  //////////////////////////////////////////////////
  always_comb begin
    state_d      = state_q;
    fetch_addr_d = fetch_addr_q;
    off_d        = off_q;
    strad_d      = strad_q;
    deliver      = 1'b0;
    dlv_instr    = rbuf_q[0];
    dlv_pc       = fetch_addr_q;

    unique case (state_q)
      fetch_pkg::IDLE: begin
        state_d = fetch_pkg::WAIT_RESP;
      end
      fetch_pkg::WAIT_RESP, fetch_pkg::FETCH_NEXT: begin
        if (port_ack_i) begin
          state_d = fetch_pkg::HAVE_WORD;
          // second word of a straddle, pc stays on the upper half
          if (state_q == fetch_pkg::FETCH_NEXT) begin
            fetch_addr_d = fetch_addr_q + 32'd4;
            strad_d      = 1'b1;
          end
        end
      end
      fetch_pkg::HAVE_WORD: begin
        if (strad_q) begin
          // upper half of the old word is the low part of the instruction
          dlv_instr = {rbuf_q[0][15:0], rbuf_q[1][31:16]};
          dlv_pc    = fetch_addr_q - 32'd2;
          if (out_free) begin
            deliver = 1'b1;
            strad_d = 1'b0;
          end
        end else if (off_q && !cur_is_c) begin
          // 32-bit instruction crosses into the next word
          state_d = fetch_pkg::FETCH_NEXT;
        end else begin
          dlv_instr = cur_is_c ? {16'h0000, cur_half} : rbuf_q[0];
          dlv_pc    = off_q ? fetch_addr_q + 32'd2 : fetch_addr_q;
          if (out_free) begin
            deliver = 1'b1;
            if (off_q || !cur_is_c) begin
              // word used up
              fetch_addr_d = fetch_addr_q + 32'd4;
              off_d        = 1'b0;
              state_d      = fetch_pkg::WAIT_RESP;
            end else begin
              // compressed in the low half, serve the upper half next
              off_d = 1'b1;
            end
          end
        end
      end
      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase

    // redirect overrides everything, restart at the target word
    if (redirect_i) begin
      deliver      = 1'b0;
      state_d      = fetch_pkg::WAIT_RESP;
      fetch_addr_d = {redirect_pc_i[fetch_pkg::XLEN-1:2], 2'b00};
      off_d        = redirect_pc_i[1];
      strad_d      = 1'b0;
    end
  end

  // request is held until the port acknowledges it
  assign port_req_o  = (state_q == fetch_pkg::WAIT_RESP) || (state_q == fetch_pkg::FETCH_NEXT);
  assign port_addr_o = (state_q == fetch_pkg::FETCH_NEXT) ? fetch_addr_q + 32'd4 : fetch_addr_q;
  assign port_drop_o = redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::IDLE;
      fetch_addr_q <= {fetch_pkg::BOOT_ADDR[fetch_pkg::XLEN-1:2], 2'b00};
      off_q        <= fetch_pkg::BOOT_ADDR[1];
      strad_q      <= 1'b0;
      out_valid_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
      off_q        <= off_d;
      strad_q      <= strad_d;
      if (redirect_i) begin
        out_valid_q <= 1'b0;
      end else if (deliver) begin
        out_valid_q <= 1'b1;
      end else if (instr_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // realignment buffer and output payload
  always_ff @(posedge clk) begin
    if (port_ack_i && !redirect_i) begin
      rbuf_q[1] <= rbuf_q[0];
      rbuf_q[0] <= port_rdata_i;
    end
    if (deliver) begin
      out_instr_q <= dlv_instr;
      out_pc_q    <= dlv_pc;
    end
  end

  assign instr_valid_o = out_valid_q;
  assign instr_o       = out_instr_q;
  assign pc_o          = out_pc_q;

  // a stalled transfer keeps its payload until taken or redirected
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !redirect_i) |=> ($stable(instr_o) && $stable(pc_o)));

endmodule

`default_nettype wire

//--- source/fetch_top.sv
/*
  fetch subsystem top
  fetch unit and its memory port share one instruction memory
  with an external data port through a round-robin arbiter
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          redirect_i,
  input  wire [fetch_pkg::XLEN-1:0]    redirect_pc_i,
  output logic                         instr_valid_o,
  input  wire                          instr_ready_i,
  output logic [fetch_pkg::XLEN-1:0]   instr_o,
  output logic [fetch_pkg::XLEN-1:0]   pc_o,
  input  wire                          data_req_i,
  input  wire                          data_we_i,
  input  wire [fetch_pkg::MEM_AW-1:0]  data_addr_i,
  input  wire [fetch_pkg::XLEN-1:0]    data_wdata_i,
  output logic                         data_gnt_o,
  output logic                         data_rvalid_o,
  output logic [fetch_pkg::XLEN-1:0]   data_rdata_o
);

  // fetch unit to port
  wire                          port_req, port_ack, port_drop;
  wire [fetch_pkg::XLEN-1:0]    port_addr, port_rdata;
  // port to arbiter
  wire                          fetch_req, fetch_gnt, fetch_rvalid;
  wire [fetch_pkg::MEM_AW-1:0]  fetch_addr;
  wire [fetch_pkg::XLEN-1:0]    fetch_rdata;
  // arbiter to memory
  wire                          mem_req, mem_we, mem_rvalid;
  wire [fetch_pkg::MEM_AW-1:0]  mem_addr;
  wire [fetch_pkg::XLEN-1:0]    mem_wdata, mem_rdata;

  fetch_unit u_fetch_unit (
    .clk(clk), .rst_n(rst_n),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .instr_valid_o(instr_valid_o), .instr_ready_i(instr_ready_i),
    .instr_o(instr_o), .pc_o(pc_o),
    .port_req_o(port_req), .port_addr_o(port_addr), .port_ack_i(port_ack),
    .port_rdata_i(port_rdata), .port_drop_o(port_drop)
  );

  fetch_mem_port u_mem_port (
    .clk(clk), .rst_n(rst_n),
    .port_req_i(port_req), .port_addr_i(port_addr), .port_ack_o(port_ack),
    .port_rdata_o(port_rdata), .port_drop_i(port_drop),
    .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr), .fetch_gnt_i(fetch_gnt),
    .fetch_rvalid_i(fetch_rvalid), .fetch_rdata_i(fetch_rdata)
  );

  mem_arbiter u_arbiter (
    .clk(clk), .rst_n(rst_n),
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_gnt_o(fetch_gnt),
    .fetch_rvalid_o(fetch_rvalid), .fetch_rdata_o(fetch_rdata),
    .data_req_i(data_req_i), .data_we_i(data_we_i), .data_addr_i(data_addr_i),
    .data_wdata_i(data_wdata_i), .data_gnt_o(data_gnt_o),
    .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
  );

  instr_mem u_mem (
    .clk(clk), .rst_n(rst_n),
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .rdata_o(mem_rdata), .rvalid_o(mem_rvalid)
  );

  // every memory response reaches the fetch port or the data port
  a_rsp_routed: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rvalid == (fetch_rvalid || data_rvalid_o));

endmodule

`default_nettype wire

//--- tests/tb_fetch_top.sv
/*
  testbench for the fetch subsystem
  loads programs through the data port, walks its own memory image to
  predict every instruction and pc, and checks the consumer stream
  under back-pressure, redirects and data-port traffic
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  // program sizes in words and stream lengths in instructions
  localparam int RESET_CYCLES = 16;
  localparam int P1_WORDS     = 16;
  localparam int P2_WORDS     = 32;
  localparam int P3_WORDS     = 160;
  localparam int REDIR_LEN    = 40;
  localparam int DATA_LEN     = 60;
  localparam int DATA_WORDS   = 8;
  localparam logic [fetch_pkg::MEM_AW-1:0] DATA_BASE = 8'd200;
  localparam logic [fetch_pkg::MEM_AW-1:0] PROG_READ = 8'd100;
  // upper bound of transfers, every word may hold two instructions
  localparam int MAX_XFERS = P1_WORDS + 2 * P2_WORDS + 2 * P3_WORDS + 2 * REDIR_LEN + DATA_LEN;
  localparam int LOADS = P1_WORDS + P2_WORDS + P3_WORDS + 3 * DATA_WORDS;
  localparam int CYCLE_LIMIT = 20 * (MAX_XFERS + LOADS) + RESET_CYCLES;

  logic clk, rst_n;
  logic redirect_i, instr_valid_o, instr_ready_i;
  logic [31:0] redirect_pc_i, instr_o, pc_o;
  logic data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
  logic [fetch_pkg::MEM_AW-1:0] data_addr_i;
  logic [31:0] data_wdata_i, data_rdata_o;

  // testbench copy of the memory contents
  logic [31:0] img [fetch_pkg::MEM_WORDS];
  logic [31:0] exp_instr [$];
  logic [31:0] exp_pc [$];
  logic [31:0] rng_state = 32'h1f8e_b9af;
  int errors = 0;
  int transfers = 0;
  int straddles = 0;
  int cycles = 0;

  fetch_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .instr_valid_o(instr_valid_o), .instr_ready_i(instr_ready_i),
    .instr_o(instr_o), .pc_o(pc_o),
    .data_req_i(data_req_i), .data_we_i(data_we_i), .data_addr_i(data_addr_i),
    .data_wdata_i(data_wdata_i), .data_gnt_o(data_gnt_o),
    .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // xorshift32 step on the shared generator
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // halfword of the image at a byte address
  function automatic logic [15:0] image_half(input logic [31:0] pc);
    logic [31:0] w;
    w = img[pc[fetch_pkg::MEM_AW+1:2]];
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  // one instruction at pc, low bits other than 11 mean compressed
  function automatic logic [31:0] ref_fetch(input logic [31:0] pc, output logic [31:0] next_pc);
    logic [15:0] lo;
    lo = image_half(pc);
    if (lo[1:0] != 2'b11) begin
      next_pc = pc + 32'd2;
      return {16'h0000, lo};
    end
    next_pc = pc + 32'd4;
    return {image_half(pc + 32'd2), lo};
  endfunction

  // queue up to count expected transfers that end at or below limit
  task automatic expect_from(input logic [31:0] start, input int count, input logic [31:0] limit);
    logic [31:0] pc, nxt, ins;
    int i;
    pc = start;
    for (i = 0; i < count; i++) begin
      ins = ref_fetch(pc, nxt);
      if (nxt > limit) break;
      exp_instr.push_back(ins);
      exp_pc.push_back(pc);
      if (pc[1] && ins[1:0] == 2'b11) straddles++;
      pc = nxt;
    end
  endtask

  // random words, mixed ones carry 32-bit opcodes in either half
  task automatic make_program(input logic [fetch_pkg::MEM_AW-1:0] first, input int nwords,
                              input logic only_32);
    logic [31:0] r, w;
    logic [fetch_pkg::MEM_AW-1:0] wa;
    int i;
    wa = first;
    for (i = 0; i < nwords; i++) begin
      r = next_rand();
      w = r;
      if (only_32 || r[20]) w[1:0] = 2'b11;
      if (!only_32 && r[4]) w[17:16] = 2'b11;
      img[wa] = w;
      wa = wa + 8'd1;
    end
  endtask

  // one data port cycle, request held until grant, then wait for rvalid
  task automatic data_access(input logic we, input logic [fetch_pkg::MEM_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_wdata_i = wdata;
    @(posedge clk);
    while (!data_gnt_o) @(posedge clk);
    @(negedge clk);
    data_req_i = 1'b0;
    data_we_i  = 1'b0;
    @(posedge clk);
    while (!data_rvalid_o) @(posedge clk);
    rdata = data_rdata_o;
  endtask

  task automatic load_program(input logic [fetch_pkg::MEM_AW-1:0] first, input int nwords);
    logic [31:0] rd;
    logic [fetch_pkg::MEM_AW-1:0] wa;
    int i;
    wa = first;
    for (i = 0; i < nwords; i++) begin
      data_access(1'b1, wa, img[wa], rd);
      wa = wa + 8'd1;
    end
  endtask

  // single-cycle redirect pulse with the consumer stalled
  task automatic redirect_to(input logic [31:0] pc);
    @(negedge clk);
    instr_ready_i = 1'b0;
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    @(negedge clk);
    redirect_i = 1'b0;
  endtask

  // consumer, runs until the expected queue drains then stalls
  task automatic run_stream(input logic random_ready);
    @(negedge clk);
    while (exp_instr.size() != 0) begin
      instr_ready_i = random_ready ? ((next_rand() % 4) != 0) : 1'b1;
      @(negedge clk);
    end
    instr_ready_i = 1'b0;
  endtask

  // writes a scratch area, reads it back and reads program words
  task automatic data_traffic();
    logic [31:0] rd;
    logic [fetch_pkg::MEM_AW-1:0] wa;
    int i;
    wa = DATA_BASE;
    for (i = 0; i < DATA_WORDS; i++) begin
      img[wa] = next_rand();
      data_access(1'b1, wa, img[wa], rd);
      wa = wa + 8'd1;
    end
    for (i = 0; i < 2 * DATA_WORDS; i++) begin
      wa = (i < DATA_WORDS) ? DATA_BASE + 8'(i) : PROG_READ + 8'(i);
      data_access(1'b0, wa, 32'h0, rd);
      check_value(rd, img[wa], "data port read");
    end
  endtask

  //////////////////////////////////////////////////
  // compare and watchdog
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n && instr_valid_o && instr_ready_i) begin
      if (exp_instr.size() == 0) begin
        $display("[ERROR] %0t: unexpected transfer of %h at pc %h", $time, instr_o, pc_o);
        errors++;
      end else begin
        check_value(pc_o, exp_pc.pop_front(), "pc");
        check_value(instr_o, exp_instr.pop_front(), "instruction");
        transfers++;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run hung after %0d cycles with %0d transfers still expected",
               cycles, exp_instr.size());
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = 32'h0;
    instr_ready_i = 1'b0;
    data_req_i    = 1'b0;
    data_we_i     = 1'b0;
    data_addr_i   = '0;
    data_wdata_i  = 32'h0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value({31'd0, instr_valid_o}, 32'd0, "valid in reset");
    check_value({31'd0, data_gnt_o}, 32'd0, "data grant in reset");
    check_value({31'd0, data_rvalid_o}, 32'd0, "data rvalid in reset");
    rst_n = 1'b1;

    // only 32-bit instructions, pc steps by 4
    make_program(8'd0, P1_WORDS, 1'b1);
    load_program(8'd0, P1_WORDS);
    redirect_to(fetch_pkg::BOOT_ADDR);
    expect_from(fetch_pkg::BOOT_ADDR, P1_WORDS, 32'(P1_WORDS * 4));
    run_stream(1'b0);

    // mixed lengths with straddles, consumer always ready
    make_program(8'd0, P2_WORDS, 1'b0);
    load_program(8'd0, P2_WORDS);
    redirect_to(fetch_pkg::BOOT_ADDR);
    straddles = 0;
    expect_from(fetch_pkg::BOOT_ADDR, 2 * P2_WORDS, 32'(P2_WORDS * 4));
    if (straddles == 0) begin
      $display("mixed program holds no straddling instruction");
      errors++;
    end
    run_stream(1'b0);

    // long program under random back-pressure
    make_program(8'd0, P3_WORDS, 1'b0);
    load_program(8'd0, P3_WORDS);
    redirect_to(fetch_pkg::BOOT_ADDR);
    expect_from(fetch_pkg::BOOT_ADDR, 2 * P3_WORDS, 32'(P3_WORDS * 4));
    run_stream(1'b1);

    // word aligned then halfword target, old path still pending
    redirect_to(32'h0000_00a0);
    expect_from(32'h0000_00a0, REDIR_LEN, 32'(P3_WORDS * 4));
    run_stream(1'b1);
    redirect_to(32'h0000_01b2);
    expect_from(32'h0000_01b2, REDIR_LEN, 32'(P3_WORDS * 4));
    run_stream(1'b1);

    // data port traffic while the fetch stream runs
    redirect_to(32'h0000_0040);
    expect_from(32'h0000_0040, DATA_LEN, 32'(P3_WORDS * 4));
    fork
      run_stream(1'b1);
      data_traffic();
    join

    repeat (4) @(negedge clk);
    $display("errors: %0d, transfers checked: %0d", errors, transfers);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
common/fetch_pkg.sv
source/instr_mem.sv
source/mem_arbiter.sv
fetch/fetch_mem_port.sv
fetch/fetch_unit.sv
source/fetch_top.sv
tests/tb_fetch_top.sv

//--- Makefile
# Verilator flow for the fetch subsystem testbench

VERILATOR    ?= verilator
TOP          := tb_fetch_top
FILELIST     := build.f
OBJ_DIR      := obj_dir
LOG          := sim.log
COMMON_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   := --lint-only
SIM_FLAGS    := --binary -j 0 -Mdir $(OBJ_DIR)
PASS_MSG     := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
